// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_pkg.sv
      - design/instr_mem.sv
      - design/fetch.sv
      - design/decode.sv
      - design/execute.sv
      - design/writeback.sv
      - design/cpu_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_clock.sv
      - test/tb_cpu_core.sv

// ==== compile.f ====
+incdir+design
design/cpu_pkg.sv
design/instr_mem.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/writeback.sv
design/cpu_core.sv
test/tb_clock.sv
test/tb_cpu_core.sv

// ==== design/cpu_core.sv ====
`include "cpu_defines.svh"

module cpu_core (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_load_we,
    input  logic [`MEM_AW-1:0]            i_load_addr,
    input  logic [`I_SIZE-1:0]            i_load_data,
    output logic                          o_retire_valid,
    output logic [`RW-1:0]                o_retire_pc,
    output logic                          o_retire_we,
    output logic [$clog2(`REG_COUNT)-1:0] o_retire_rd,
    output logic [`RW-1:0]                o_retire_value,
    output logic                          o_halted
);

    logic [`RW-1:0]                req_addr;
    logic                          req_active;
    logic [`I_SIZE-1:0]            req_data;
    logic                          req_data_valid;
    logic                          submit;
    logic [`I_SIZE-1:0]            instr;
    logic                          jmp_predict;
    logic                          next_ready;
    logic                          flush;
    logic [`RW-1:0]                exec_pc;
    logic                          dec_valid;
    cpu_pkg::opcode_e              dec_opcode;
    logic [$clog2(`REG_COUNT)-1:0] dec_rd;
    logic [$clog2(`REG_COUNT)-1:0] dec_rs;
    logic [`RW-1:0]                dec_imm;
    logic                          dec_predict;
    logic                          ex_ready;
    logic [$clog2(`REG_COUNT)-1:0] rd_sel;
    logic [$clog2(`REG_COUNT)-1:0] rs_sel;
    logic [`RW-1:0]                rd_val;
    logic [`RW-1:0]                rs_val;
    logic                          res_valid;
    logic                          res_we;
    logic [$clog2(`REG_COUNT)-1:0] res_rd;
    logic [`RW-1:0]                res_value;
    logic [`RW-1:0]                res_pc;

    instr_mem i_instr_mem (
        .i_clk, .i_rst, .i_load_we, .i_load_addr, .i_load_data,
        .i_req_addr(req_addr), .i_req_active(req_active),
        .o_req_data(req_data), .o_req_data_valid(req_data_valid)
    );

    fetch i_fetch (
        .i_clk, .i_rst,
        .o_req_addr(req_addr), .o_req_active(req_active),
        .i_req_data(req_data), .i_req_data_valid(req_data_valid),
        .i_next_ready(next_ready), .o_submit(submit), .o_instr(instr),
        .o_jmp_predict(jmp_predict), .i_flush(flush), .i_exec_pc(exec_pc)
    );

    decode i_decode (
        .i_clk, .i_rst,
        .i_submit(submit), .i_instr(instr), .i_jmp_predict(jmp_predict),
        .i_flush(flush), .i_ex_ready(ex_ready), .o_next_ready(next_ready),
        .o_valid(dec_valid), .o_opcode(dec_opcode), .o_rd(dec_rd), .o_rs(dec_rs),
        .o_imm(dec_imm), .o_predict(dec_predict)
    );

    execute i_execute (
        .i_clk, .i_rst,
        .i_valid(dec_valid), .i_opcode(dec_opcode), .i_rd(dec_rd), .i_rs(dec_rs),
        .i_imm(dec_imm), .i_predict(dec_predict), .i_rd_val(rd_val), .i_rs_val(rs_val),
        .o_ready(ex_ready), .o_rd_sel(rd_sel), .o_rs_sel(rs_sel),
        .o_flush(flush), .o_exec_pc(exec_pc),
        .o_res_valid(res_valid), .o_res_we(res_we), .o_res_rd(res_rd),
        .o_res_value(res_value), .o_res_pc(res_pc), .o_halted
    );

    writeback i_writeback (
        .i_clk, .i_rst,
        .i_rd_sel(rd_sel), .i_rs_sel(rs_sel), .o_rd_val(rd_val), .o_rs_val(rs_val),
        .i_res_valid(res_valid), .i_res_we(res_we), .i_res_rd(res_rd),
        .i_res_value(res_value), .i_res_pc(res_pc),
        .o_retire_valid, .o_retire_pc, .o_retire_we, .o_retire_rd, .o_retire_value
    );

endmodule

// ==== design/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path and address width
`define RW 16

// instruction word width
`define I_SIZE 32

// architectural registers
`define REG_COUNT 16

// instruction memory address bits, 256 words
`define MEM_AW 8

// cycles a multiply keeps execute busy
`define MUL_CYCLES 4

`endif

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    // instruction opcodes, bits [6:0] of the word
    typedef enum logic [6:0] {
        OP_NOP  = 7'h00,
        OP_LDI  = 7'h01,
        OP_ADD  = 7'h02,
        OP_SUB  = 7'h03,
        OP_AND  = 7'h04,
        OP_MUL  = 7'h05,
        OP_JMP  = 7'h0e,
        OP_JAL  = 7'h0f,
        OP_HALT = 7'h7f
    } opcode_e;

    // jump condition, carried in the rd field
    typedef enum logic [3:0] {
        C_ALWAYS  = 4'h0,
        C_ZERO    = 4'h1,
        C_NONZERO = 4'h2
    } cond_e;

    typedef enum logic [1:0] {
        EX_RUN,
        EX_MUL,
        EX_HALT
    } exec_state_e;

endpackage

// ==== design/decode.sv ====
`include "cpu_defines.svh"

module decode (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_submit,
    input  logic [`I_SIZE-1:0]          i_instr,
    input  logic                        i_jmp_predict,
    input  logic                        i_flush,
    input  logic                        i_ex_ready,
    output logic                        o_next_ready,
    output logic                        o_valid,
    output cpu_pkg::opcode_e            o_opcode,
    output logic [$clog2(`REG_COUNT)-1:0] o_rd,
    output logic [$clog2(`REG_COUNT)-1:0] o_rs,
    output logic [`RW-1:0]              o_imm,
    output logic                        o_predict
);

    cpu_pkg::opcode_e                dec_op;
    cpu_pkg::opcode_e                q_op   [2];
    logic [$clog2(`REG_COUNT)-1:0]   q_rd   [2];
    logic [$clog2(`REG_COUNT)-1:0]   q_rs   [2];
    logic [`RW-1:0]                  q_imm  [2];
    logic                            q_pred [2];
    logic [1:0]                      count;
    logic                            wr_ptr;
    logic                            rd_ptr;
    logic                            pop;

    // anything not in the ISA runs as a NOP
    always_comb begin
        case (i_instr[6:0])
            cpu_pkg::OP_LDI, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
            cpu_pkg::OP_MUL, cpu_pkg::OP_JMP, cpu_pkg::OP_JAL, cpu_pkg::OP_HALT:
                dec_op = cpu_pkg::opcode_e'(i_instr[6:0]);
            default:
                dec_op = cpu_pkg::OP_NOP;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_submit) begin
            q_op[wr_ptr]   <= dec_op;
            q_rd[wr_ptr]   <= i_instr[10:7];
            q_rs[wr_ptr]   <= i_instr[14:11];
            q_imm[wr_ptr]  <= i_instr[31:16];
            q_pred[wr_ptr] <= i_jmp_predict;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || i_flush) begin
            count  <= 2'd0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            if (i_submit) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            count <= count + 2'(i_submit) - 2'(pop);
        end
    end

    assign pop = o_valid && i_ex_ready;
    assign o_valid = (count != 2'd0);
    assign o_opcode = q_op[rd_ptr];
    assign o_rd = q_rd[rd_ptr];
    assign o_rs = q_rs[rd_ptr];
    assign o_imm = q_imm[rd_ptr];
    assign o_predict = q_pred[rd_ptr];

    // room for whatever fetch may send next cycle
    assign o_next_ready = !(count == 2'd2 || (count == 2'd1 && i_submit));

    a_no_push_when_full: assert property (
        @(posedge i_clk) disable iff (i_rst) i_submit |-> count != 2'd2
    );

endmodule

// ==== design/execute.sv ====
`include "cpu_defines.svh"

module execute (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_valid,
    input  cpu_pkg::opcode_e              i_opcode,
    input  logic [$clog2(`REG_COUNT)-1:0] i_rd,
    input  logic [$clog2(`REG_COUNT)-1:0] i_rs,
    input  logic [`RW-1:0]                i_imm,
    input  logic                          i_predict,
    input  logic [`RW-1:0]                i_rd_val,
    input  logic [`RW-1:0]                i_rs_val,
    output logic                          o_ready,
    output logic [$clog2(`REG_COUNT)-1:0] o_rd_sel,
    output logic [$clog2(`REG_COUNT)-1:0] o_rs_sel,
    output logic                          o_flush,
    output logic [`RW-1:0]                o_exec_pc,
    output logic                          o_res_valid,
    output logic                          o_res_we,
    output logic [$clog2(`REG_COUNT)-1:0] o_res_rd,
    output logic [`RW-1:0]                o_res_value,
    output logic [`RW-1:0]                o_res_pc,
    output logic                          o_halted
);

    // multiplier bits consumed per cycle
    localparam int CHUNK = `RW / `MUL_CYCLES;
    localparam int CNT_W = $clog2(`MUL_CYCLES);

    cpu_pkg::exec_state_e state;
    logic [`RW-1:0]       pc;
    logic [`RW-1:0]       next_pc;
    logic                 fire;
    logic                 taken;
    logic                 alu_we;
    logic [`RW-1:0]       alu_val;
    logic [`RW-1:0]       mul_a;
    logic [`RW-1:0]       mul_b;
    logic [`RW-1:0]       mul_acc;
    logic [`RW-1:0]       mul_sum;
    logic [CNT_W-1:0]     mul_cnt;

    assign o_rd_sel = i_rd;
    assign o_rs_sel = i_rs;
    assign o_ready = (state == cpu_pkg::EX_RUN);
    assign o_halted = (state == cpu_pkg::EX_HALT);
    assign fire = i_valid && o_ready;

    always_comb begin
        taken = 1'b0;
        if (i_opcode == cpu_pkg::OP_JAL) begin
            taken = 1'b1;
        end else if (i_opcode == cpu_pkg::OP_JMP) begin
            case (cpu_pkg::cond_e'(i_rd))
                cpu_pkg::C_ALWAYS:  taken = 1'b1;
                cpu_pkg::C_ZERO:    taken = (i_rs_val == '0);
                cpu_pkg::C_NONZERO: taken = (i_rs_val != '0);
                default:            taken = 1'b0;
            endcase
        end
    end

    assign next_pc = taken ? i_imm : pc + `RW'(1);
    assign o_exec_pc = next_pc;
    // fetch guessed the other direction
    assign o_flush = fire && (taken != i_predict);

    always_comb begin
        alu_we = 1'b1;
        case (i_opcode)
            cpu_pkg::OP_LDI: alu_val = i_imm;
            cpu_pkg::OP_ADD: alu_val = i_rd_val + i_rs_val;
            cpu_pkg::OP_SUB: alu_val = i_rd_val - i_rs_val;
            cpu_pkg::OP_AND: alu_val = i_rd_val & i_rs_val;
            cpu_pkg::OP_JAL: alu_val = pc + `RW'(1);
            cpu_pkg::OP_MUL: alu_val = '0;
            default: begin
                alu_we  = 1'b0;
                alu_val = '0;
            end
        endcase
    end

    // shift-add multiply, one chunk of rs per cycle
    assign mul_sum = mul_acc + mul_a * `RW'(mul_b[CHUNK-1:0]);

    always_ff @(posedge i_clk) begin
        if (fire) begin
            o_res_rd    <= i_rd;
            o_res_pc    <= pc;
            o_res_we    <= alu_we;
            o_res_value <= alu_val;
            mul_a       <= i_rd_val;
            mul_b       <= i_rs_val;
            mul_acc     <= '0;
        end else if (state == cpu_pkg::EX_MUL) begin
            mul_a       <= mul_a << CHUNK;
            mul_b       <= mul_b >> CHUNK;
            mul_acc     <= mul_sum;
            o_res_value <= mul_sum;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= cpu_pkg::EX_RUN;
            pc          <= '0;
            mul_cnt     <= '0;
            o_res_valid <= 1'b0;
        end else begin
            o_res_valid <= 1'b0;
            case (state)
                cpu_pkg::EX_RUN: begin
                    if (fire) begin
                        pc <= next_pc;
                        if (i_opcode == cpu_pkg::OP_MUL) begin
                            state   <= cpu_pkg::EX_MUL;
                            mul_cnt <= '0;
                        end else begin
                            o_res_valid <= 1'b1;
                            if (i_opcode == cpu_pkg::OP_HALT) begin
                                state <= cpu_pkg::EX_HALT;
                            end
                        end
                    end
                end
                cpu_pkg::EX_MUL: begin
                    mul_cnt <= mul_cnt + CNT_W'(1);
                    if (mul_cnt == CNT_W'(`MUL_CYCLES - 1)) begin
                        state       <= cpu_pkg::EX_RUN;
                        o_res_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= cpu_pkg::EX_HALT;
                end
            endcase
        end
    end

    // decode is emptied by the flush, so no second one can follow
    a_flush_single: assert property (
        @(posedge i_clk) disable iff (i_rst) o_flush |=> !o_flush
    );

    // an accepted multiply keeps execute busy for exactly MUL_CYCLES cycles
    a_busy_in_mul: assert property (
        @(posedge i_clk) disable iff (i_rst)
            fire && (i_opcode == cpu_pkg::OP_MUL) |=> !o_ready [*`MUL_CYCLES] ##1 o_ready
    );

endmodule

// ==== design/fetch.sv ====
`include "cpu_defines.svh"

module fetch (
    input  logic                i_clk,
    input  logic                i_rst,
    output logic [`RW-1:0]      o_req_addr,
    output logic                o_req_active,
    input  logic [`I_SIZE-1:0]  i_req_data,
    input  logic                i_req_data_valid,
    input  logic                i_next_ready,
    output logic                o_submit,
    output logic [`I_SIZE-1:0]  o_instr,
    output logic                o_jmp_predict,
    input  logic                i_flush,
    input  logic [`RW-1:0]      i_exec_pc
);

    // word parked here while decode has no room
    logic [`I_SIZE-1:0] hold_instr;
    logic               hold_valid;
    // pc of the word in o_instr
    logic [`RW-1:0]     fetch_pc;
    logic [`RW-1:0]     next_fetch_pc;
    logic               drop_resp;
    logic [`RW-1:0]     instr_imm;

    assign instr_imm = o_instr[31:16];
    assign o_req_addr = next_fetch_pc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            // all ones so that the first request goes to address 0
            fetch_pc     <= '1;
            o_instr      <= '0;
            o_submit     <= 1'b0;
            o_req_active <= 1'b0;
            hold_valid   <= 1'b0;
            drop_resp    <= 1'b0;
        end else if (i_flush) begin
            o_submit     <= 1'b0;
            o_req_active <= 1'b0;
            hold_valid   <= 1'b0;
            // a NOP in o_instr makes the next address exec_pc
            fetch_pc     <= i_exec_pc - `RW'(1);
            o_instr      <= '0;
            drop_resp    <= o_req_active;
        end else if (i_req_data_valid && drop_resp) begin
            // stale word from the old path
            drop_resp    <= 1'b0;
            o_req_active <= 1'b1;
            o_submit     <= 1'b0;
        end else if (i_req_data_valid && i_next_ready) begin
            o_instr      <= i_req_data;
            fetch_pc     <= next_fetch_pc;
            o_submit     <= 1'b1;
            o_req_active <= 1'b1;
        end else if (i_req_data_valid) begin
            hold_instr   <= i_req_data;
            hold_valid   <= 1'b1;
            o_req_active <= 1'b0;
            o_submit     <= 1'b0;
        end else if (hold_valid && i_next_ready) begin
            o_instr      <= hold_instr;
            fetch_pc     <= next_fetch_pc;
            o_submit     <= 1'b1;
            hold_valid   <= 1'b0;
            o_req_active <= 1'b1;
        end else begin
            // one request in flight at a time, none while holding
            o_req_active <= !hold_valid && !o_req_active;
            o_submit     <= 1'b0;
        end
    end

    // static prediction on the last submitted word
    always_comb begin
        next_fetch_pc = fetch_pc + `RW'(1);
        o_jmp_predict = 1'b0;
        if (o_instr[6:0] == cpu_pkg::OP_JAL) begin
            next_fetch_pc = instr_imm;
            o_jmp_predict = 1'b1;
        end else if (o_instr[6:0] == cpu_pkg::OP_JMP) begin
            // backward conditional jumps assumed taken
            if (o_instr[10:7] == cpu_pkg::C_ALWAYS || fetch_pc > instr_imm) begin
                next_fetch_pc = instr_imm;
                o_jmp_predict = 1'b1;
            end
        end
    end

    // nothing from the dropped path reaches decode before the restart word returns
    a_no_submit_after_flush: assert property (
        @(posedge i_clk) disable iff (i_rst) i_flush |=> !o_submit [*3]
    );

endmodule

// ==== design/instr_mem.sv ====
`include "cpu_defines.svh"

module instr_mem (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_load_we,
    input  logic [`MEM_AW-1:0]  i_load_addr,
    input  logic [`I_SIZE-1:0]  i_load_data,
    input  logic [`RW-1:0]      i_req_addr,
    input  logic                i_req_active,
    output logic [`I_SIZE-1:0]  o_req_data,
    output logic                o_req_data_valid
);

    logic [`I_SIZE-1:0] mem [0:(1 << `MEM_AW)-1];

    // program load, only used while the core sits in reset
    always_ff @(posedge i_clk) begin
        if (i_load_we) begin
            mem[i_load_addr] <= i_load_data;
        end
        if (i_req_active) begin
            o_req_data <= mem[i_req_addr[`MEM_AW-1:0]];
        end
    end

    // every request is answered in the next cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_req_data_valid <= 1'b0;
        end else begin
            o_req_data_valid <= i_req_active;
        end
    end

endmodule

// ==== design/writeback.sv ====
`include "cpu_defines.svh"

module writeback (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic [$clog2(`REG_COUNT)-1:0] i_rd_sel,
    input  logic [$clog2(`REG_COUNT)-1:0] i_rs_sel,
    output logic [`RW-1:0]                o_rd_val,
    output logic [`RW-1:0]                o_rs_val,
    input  logic                          i_res_valid,
    input  logic                          i_res_we,
    input  logic [$clog2(`REG_COUNT)-1:0] i_res_rd,
    input  logic [`RW-1:0]                i_res_value,
    input  logic [`RW-1:0]                i_res_pc,
    output logic                          o_retire_valid,
    output logic [`RW-1:0]                o_retire_pc,
    output logic                          o_retire_we,
    output logic [$clog2(`REG_COUNT)-1:0] o_retire_rd,
    output logic [`RW-1:0]                o_retire_value
);

    logic [`RW-1:0] regs [`REG_COUNT];
    logic           wr_en;

    assign wr_en = i_res_valid && i_res_we;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_res_rd] <= i_res_value;
        end
    end

    // a register written this cycle is read with its new value
    assign o_rd_val = (wr_en && i_res_rd == i_rd_sel) ? i_res_value : regs[i_rd_sel];
    assign o_rs_val = (wr_en && i_res_rd == i_rs_sel) ? i_res_value : regs[i_rs_sel];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_retire_valid <= 1'b0;
        end else begin
            o_retire_valid <= i_res_valid;
        end
        o_retire_pc    <= i_res_pc;
        o_retire_we    <= i_res_we;
        o_retire_rd    <= i_res_rd;
        o_retire_value <= i_res_value;
    end

endmodule

// ==== test/tb_clock.sv ====
module tb_clock (
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 10;

    // 20 ns period
    initial begin
        o_clk = 1'b0;
        forever begin
            #10 o_clk = ~o_clk;
        end
    end

    // reset drops just after the tenth rising edge
    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_rst = 1'b0;
    end

endmodule

// ==== test/tb_cpu_core.sv ====
`include "cpu_defines.svh"

module tb_cpu_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS = 1 << `MEM_AW;
    localparam int RESET_CYCLES = 10;
    localparam int RETIRE_BUDGET = 12;
    localparam int DRAIN_CYCLES = 8;
    localparam int MODEL_STEP_LIMIT = 1000;

    logic                 clk;
    logic                 por_rst;
    logic                 load_rst;
    logic                 dut_rst;
    logic                 load_we;
    logic [`MEM_AW-1:0]   load_addr;
    logic [`I_SIZE-1:0]   load_data;
    logic                 retire_valid;
    logic [`RW-1:0]       retire_pc;
    logic                 retire_we;
    logic [3:0]           retire_rd;
    logic [`RW-1:0]       retire_value;
    logic                 halted;

    // image of the instruction memory, also read by the reference model
    logic [`I_SIZE-1:0]   prog [MEM_WORDS];
    logic [`RW-1:0]       exp_pc [$];
    logic                 exp_we [$];
    logic [3:0]           exp_rd [$];
    logic [`RW-1:0]       exp_value [$];
    logic [`RW-1:0]       got_pc [$];
    logic                 got_we [$];
    logic [3:0]           got_rd [$];
    logic [`RW-1:0]       got_value [$];
    logic [31:0]          rng_state;
    int                   cycle_count = 0;
    int                   timeout_limit = RESET_CYCLES;
    int                   error_count = 0;
    int                   check_count = 0;
    int                   test_count = 0;
    int                   failed_tests = 0;

    tb_clock i_tb_clock (
        .o_clk(clk),
        .o_rst(por_rst)
    );

    assign dut_rst = por_rst || load_rst;

    cpu_core i_cpu_core (
        .i_clk(clk), .i_rst(dut_rst),
        .i_load_we(load_we), .i_load_addr(load_addr), .i_load_data(load_data),
        .o_retire_valid(retire_valid), .o_retire_pc(retire_pc), .o_retire_we(retire_we),
        .o_retire_rd(retire_rd), .o_retire_value(retire_value), .o_halted(halted)
    );

    // retire reports are taken on the falling edge, away from the register updates
    always @(negedge clk) begin
        if (!dut_rst && retire_valid) begin
            got_pc.push_back(retire_pc);
            got_we.push_back(retire_we);
            got_rd.push_back(retire_rd);
            got_value.push_back(retire_value);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("run stopped after %0d cycles, the core did not halt in time", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] encode_instr(logic [6:0] op, logic [3:0] rd,
                                                 logic [3:0] rs, logic [15:0] imm);
        return {imm, 1'b0, rs, rd, op};
    endfunction

    function automatic logic [31:0] xorshift32(logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("Fail %s: expected %h, got %h", name, expected, got);
            error_count++;
        end
    endtask

    // unused words hold HALT with the address in the immediate
    task automatic fill_program_image();
        for (int a = 0; a < MEM_WORDS; a++) begin
            prog[a] = encode_instr(cpu_pkg::OP_HALT, 4'h0, 4'h0, {8'h5a, 8'(a)});
        end
    endtask

    // ISA interpreter, builds the expected retire list along the taken path
    task automatic run_model();
        logic [`RW-1:0]     regs [`REG_COUNT];
        logic [`RW-1:0]     pc;
        logic [`I_SIZE-1:0] word;
        logic [6:0]         op;
        logic [3:0]         rd;
        logic [3:0]         rs;
        logic [`RW-1:0]     imm;
        logic [`RW-1:0]     value;
        logic               we;
        logic               taken;
        logic               done;
        int                 steps;
        for (int r = 0; r < `REG_COUNT; r++) begin
            regs[r] = '0;
        end
        exp_pc.delete();
        exp_we.delete();
        exp_rd.delete();
        exp_value.delete();
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < MODEL_STEP_LIMIT) begin
            word = prog[pc[`MEM_AW-1:0]];
            op = word[6:0];
            rd = word[10:7];
            rs = word[14:11];
            imm = word[31:16];
            we = 1'b1;
            value = '0;
            taken = 1'b0;
            case (op)
                cpu_pkg::OP_LDI: value = imm;
                cpu_pkg::OP_ADD: value = regs[rd] + regs[rs];
                cpu_pkg::OP_SUB: value = regs[rd] - regs[rs];
                cpu_pkg::OP_AND: value = regs[rd] & regs[rs];
                cpu_pkg::OP_MUL: value = regs[rd] * regs[rs];
                cpu_pkg::OP_JAL: begin
                    value = pc + 16'd1;
                    taken = 1'b1;
                end
                cpu_pkg::OP_JMP: begin
                    we = 1'b0;
                    case (rd)
                        cpu_pkg::C_ALWAYS:  taken = 1'b1;
                        cpu_pkg::C_ZERO:    taken = (regs[rs] == '0);
                        cpu_pkg::C_NONZERO: taken = (regs[rs] != '0);
                        default:            taken = 1'b0;
                    endcase
                end
                cpu_pkg::OP_HALT: begin
                    we = 1'b0;
                    done = 1'b1;
                end
                default: we = 1'b0;
            endcase
            exp_pc.push_back(pc);
            exp_we.push_back(we);
            exp_rd.push_back(rd);
            exp_value.push_back(value);
            if (we) begin
                regs[rd] = value;
            end
            pc = taken ? imm : pc + 16'd1;
            steps++;
        end
    endtask

    // load the image under reset, run until halt and compare the retire list
    task automatic run_program(string name);
        int errors_before;
        int n;
        errors_before = error_count;
        run_model();
        timeout_limit += MEM_WORDS + 4 + exp_pc.size() * RETIRE_BUDGET + DRAIN_CYCLES;
        @(posedge clk);
        #1;
        load_rst = 1'b1;
        for (int a = 0; a < MEM_WORDS; a++) begin
            load_we = 1'b1;
            load_addr = 8'(a);
            load_data = prog[a];
            @(posedge clk);
            #1;
        end
        load_we = 1'b0;
        got_pc.delete();
        got_we.delete();
        got_rd.delete();
        got_value.delete();
        load_rst = 1'b0;
        while (!halted) begin
            @(posedge clk);
            #1;
        end
        // anything retiring after HALT shows up as an extra entry
        repeat (DRAIN_CYCLES) @(posedge clk);
        #1;
        check_value({name, " o_halted"}, halted, 1);
        check_value({name, " retire count"}, got_pc.size(), exp_pc.size());
        n = (got_pc.size() < exp_pc.size()) ? got_pc.size() : exp_pc.size();
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("%s retire_pc[%0d]", name, i), got_pc[i], exp_pc[i]);
            check_value($sformatf("%s retire_we[%0d]", name, i), got_we[i], exp_we[i]);
            if (exp_we[i]) begin
                check_value($sformatf("%s retire_rd[%0d]", name, i), got_rd[i], exp_rd[i]);
                check_value($sformatf("%s retire_value[%0d]", name, i),
                            got_value[i], exp_value[i]);
            end
        end
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: %0d instructions retired, all matched", name, got_pc.size());
        end else begin
            failed_tests++;
            $display("%s: %0d mismatches", name, error_count - errors_before);
        end
    endtask

    task automatic test_straight_line();
        fill_program_image();
        prog[0] = encode_instr(cpu_pkg::OP_LDI, 4'd1, 4'd0, 16'h1234);
        prog[1] = encode_instr(cpu_pkg::OP_LDI, 4'd2, 4'd0, 16'h00ff);
        prog[2] = encode_instr(cpu_pkg::OP_LDI, 4'd3, 4'd0, 16'h0f0f);
        prog[3] = encode_instr(cpu_pkg::OP_ADD, 4'd3, 4'd1, 16'h0);
        prog[4] = encode_instr(cpu_pkg::OP_SUB, 4'd2, 4'd1, 16'h0);
        prog[5] = encode_instr(cpu_pkg::OP_AND, 4'd1, 4'd2, 16'h0);
        prog[6] = encode_instr(cpu_pkg::OP_NOP, 4'd0, 4'd0, 16'h0);
        prog[7] = encode_instr(cpu_pkg::OP_LDI, 4'd15, 4'd0, 16'hffff);
        prog[8] = encode_instr(cpu_pkg::OP_ADD, 4'd15, 4'd15, 16'h0);
        prog[9] = encode_instr(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'h0);
        run_program("straight_line");
    endtask

    // MULs hold execute, so decode fills and fetch parks a word
    task automatic test_dependent_mul();
        fill_program_image();
        prog[0] = encode_instr(cpu_pkg::OP_LDI, 4'd1, 4'd0, 16'd3);
        prog[1] = encode_instr(cpu_pkg::OP_LDI, 4'd2, 4'd0, 16'd5);
        prog[2] = encode_instr(cpu_pkg::OP_ADD, 4'd1, 4'd2, 16'h0);
        prog[3] = encode_instr(cpu_pkg::OP_ADD, 4'd1, 4'd1, 16'h0);
        prog[4] = encode_instr(cpu_pkg::OP_MUL, 4'd1, 4'd2, 16'h0);
        prog[5] = encode_instr(cpu_pkg::OP_MUL, 4'd1, 4'd2, 16'h0);
        prog[6] = encode_instr(cpu_pkg::OP_MUL, 4'd2, 4'd1, 16'h0);
        prog[7] = encode_instr(cpu_pkg::OP_SUB, 4'd2, 4'd1, 16'h0);
        prog[8] = encode_instr(cpu_pkg::OP_MUL, 4'd3, 4'd2, 16'h0);
        prog[9] = encode_instr(cpu_pkg::OP_LDI, 4'd3, 4'd0, 16'h1234);
        prog[10] = encode_instr(cpu_pkg::OP_MUL, 4'd3, 4'd3, 16'h0);
        prog[11] = encode_instr(cpu_pkg::OP_AND, 4'd3, 4'd2, 16'h0);
        prog[12] = encode_instr(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'h0);
        run_program("dependent_mul");
    endtask

    task automatic test_countdown_loop();
        fill_program_image();
        prog[0] = encode_instr(cpu_pkg::OP_LDI, 4'd1, 4'd0, 16'd5);
        prog[1] = encode_instr(cpu_pkg::OP_LDI, 4'd2, 4'd0, 16'd1);
        prog[2] = encode_instr(cpu_pkg::OP_SUB, 4'd1, 4'd2, 16'h0);
        prog[3] = encode_instr(cpu_pkg::OP_JMP, cpu_pkg::C_NONZERO, 4'd1, 16'd2);
        prog[4] = encode_instr(cpu_pkg::OP_LDI, 4'd3, 4'd0, 16'h00aa);
        prog[5] = encode_instr(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'h0);
        run_program("countdown_loop");
    endtask

    task automatic test_forward_jumps();
        fill_program_image();
        prog[0] = encode_instr(cpu_pkg::OP_LDI, 4'd1, 4'd0, 16'd0);
        prog[1] = encode_instr(cpu_pkg::OP_LDI, 4'd2, 4'd0, 16'd7);
        prog[2] = encode_instr(cpu_pkg::OP_JMP, cpu_pkg::C_ZERO, 4'd1, 16'd5);
        prog[3] = encode_instr(cpu_pkg::OP_LDI, 4'd3, 4'd0, 16'h0bad);
        prog[4] = encode_instr(cpu_pkg::OP_LDI, 4'd4, 4'd0, 16'h0bad);
        prog[5] = encode_instr(cpu_pkg::OP_JMP, cpu_pkg::C_ZERO, 4'd2, 16'd8);
        prog[6] = encode_instr(cpu_pkg::OP_ADD, 4'd2, 4'd2, 16'h0);
        prog[7] = encode_instr(cpu_pkg::OP_JMP, cpu_pkg::C_NONZERO, 4'd1, 16'd9);
        prog[8] = encode_instr(cpu_pkg::OP_LDI, 4'd5, 4'd0, 16'h0055);
        prog[9] = encode_instr(cpu_pkg::OP_JMP, cpu_pkg::C_NONZERO, 4'd2, 16'd11);
        prog[10] = encode_instr(cpu_pkg::OP_LDI, 4'd6, 4'd0, 16'h0bad);
        prog[11] = encode_instr(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'h0);
        run_program("forward_jumps");
    endtask

    task automatic test_jal_halt();
        fill_program_image();
        prog[0] = encode_instr(cpu_pkg::OP_LDI, 4'd1, 4'd0, 16'd3);
        prog[1] = encode_instr(cpu_pkg::OP_JAL, 4'd7, 4'd0, 16'd4);
        prog[2] = encode_instr(cpu_pkg::OP_LDI, 4'd2, 4'd0, 16'h0bad);
        prog[3] = encode_instr(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'h0);
        prog[4] = encode_instr(cpu_pkg::OP_ADD, 4'd1, 4'd7, 16'h0);
        prog[5] = encode_instr(cpu_pkg::OP_JMP, cpu_pkg::C_ALWAYS, 4'd0, 16'd7);
        prog[6] = encode_instr(cpu_pkg::OP_LDI, 4'd3, 4'd0, 16'h0bad);
        prog[7] = encode_instr(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'h0);
        prog[8] = encode_instr(cpu_pkg::OP_LDI, 4'd4, 4'd0, 16'h0bad);
        run_program("jal_halt");
    endtask

    task automatic test_random_alu();
        logic [6:0] op;
        fill_program_image();
        for (int i = 0; i < 40; i++) begin
            rng_state = xorshift32(rng_state);
            case (rng_state[2:0])
                3'd0, 3'd1: op = cpu_pkg::OP_LDI;
                3'd2, 3'd7: op = cpu_pkg::OP_ADD;
                3'd3:       op = cpu_pkg::OP_SUB;
                3'd4:       op = cpu_pkg::OP_AND;
                default:    op = cpu_pkg::OP_MUL;
            endcase
            prog[i] = encode_instr(op, rng_state[10:7], rng_state[14:11], rng_state[31:16]);
        end
        prog[40] = encode_instr(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'h0);
        run_program("random_alu");
    endtask

    initial begin
        load_rst = 1'b0;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        rng_state = 32'h4b1b0354;
        test_straight_line();
        test_dependent_mul();
        test_countdown_loop();
        test_forward_jumps();
        test_jal_halt();
        test_random_alu();
        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
